// ==== flist.f ====
+incdir+include
hdl/dma_pkg.sv
hdl/dma_csr.sv
hdl/dma_read_master.sv
hdl/lane_checksum.sv
hdl/dma_write_master.sv
hdl/dma_top.sv
testbench/dma_chk.sv
testbench/dma_tb.sv

// ==== hdl/dma_csr.sv ====
/* register slave of the DMA engine, no wait-request, read data one cycle late
   go and clear pulse one cycle after a control write with byte enable 0 set
   status done is set on the rising edge of done from the write master */
`default_nettype none
`include "dma_settings.svh"

module dma_csr
(
	input wire clk,
	input wire reset,
	input wire [2:0] slave_address,
	input wire slave_read,
	output logic [31:0] slave_readdata,
	input wire slave_write,
	input wire [31:0] slave_writedata,
	input wire [3:0] slave_byteenable,
	input wire done,
	input wire [3:0][7:0] lane_sum,
	output dma_pkg::dma_cmd_s cmd,
	output logic go,
	output logic clear,
	output logic irq
);

	logic [31:0] status_reg;
	logic [31:0] read_addr_reg;
	logic [31:0] write_addr_reg;
	logic [31:0] length_reg;
	logic [31:0] control_reg;
	logic [31:0] readdata_mux;
	logic done_q;	// previous done, preset high
	logic done_rise;
	logic wr_status;
	logic wr_read;
	logic wr_write;
	logic wr_length;
	logic wr_control;

	// merge the enabled bytes of a write into a register
	function automatic logic [31:0] be_merge(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] be);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < 4; i++)
		begin
			if (be[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	assign wr_status = slave_write && (slave_address == `DMA_ADDR_STATUS);
	assign wr_read = slave_write && (slave_address == `DMA_ADDR_READ);
	assign wr_write = slave_write && (slave_address == `DMA_ADDR_WRITE);
	assign wr_length = slave_write && (slave_address == `DMA_ADDR_LENGTH);
	assign wr_control = slave_write && (slave_address == `DMA_ADDR_CONTROL);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_addr_reg <= '0;
			write_addr_reg <= '0;
			length_reg <= '0;
			control_reg <= '0;
		end
		else
		begin
			if (wr_read)
				read_addr_reg <= be_merge(read_addr_reg, slave_writedata, slave_byteenable);
			if (wr_write)
				write_addr_reg <= be_merge(write_addr_reg, slave_writedata, slave_byteenable);
			if (wr_length)
				length_reg <= be_merge(length_reg, slave_writedata, slave_byteenable);
			if (wr_control)
				control_reg <= be_merge(control_reg, slave_writedata, slave_byteenable);
		end
	end

	// strobes come from the write itself, so they line up with the new control value
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			go <= 1'b0;
			clear <= 1'b0;
		end
		else
		begin
			go <= wr_control && slave_byteenable[0] && slave_writedata[`DMA_CTRL_GO];
			clear <= wr_control && slave_byteenable[0] && slave_writedata[`DMA_CTRL_CLEAR];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			done_q <= 1'b1;	// done is high out of reset, no false edge
		else
			done_q <= done;
	end
	assign done_rise = done && !done_q;	// last write has left

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			status_reg <= '0;
		else if (done_rise)
			status_reg <= 32'h1;	// done, not busy
		else if (go)
			status_reg <= 32'h2;	// busy
		else if (wr_status)
			status_reg <= '0;	// clear on write, drops irq too
	end

	always_comb
	begin
		case (slave_address)
			`DMA_ADDR_STATUS: readdata_mux = status_reg;
			`DMA_ADDR_READ: readdata_mux = read_addr_reg;
			`DMA_ADDR_WRITE: readdata_mux = write_addr_reg;
			`DMA_ADDR_LENGTH: readdata_mux = length_reg;
			`DMA_ADDR_CHECKSUM: readdata_mux = lane_sum;	// byte k is lane k
			`DMA_ADDR_CONTROL: readdata_mux = control_reg;
			default: readdata_mux = '0;	// unmapped
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			slave_readdata <= '0;
		else if (slave_read)
			slave_readdata <= readdata_mux;	// one cycle read latency
	end

	assign irq = status_reg[0] && control_reg[`DMA_CTRL_IRQ_EN];

	assign cmd.read_addr = read_addr_reg;
	assign cmd.write_addr = write_addr_reg;
	assign cmd.length = length_reg;	// shared by both masters
	assign cmd.fixed_read = control_reg[`DMA_CTRL_RCON];
	assign cmd.fixed_write = control_reg[`DMA_CTRL_WCON];

endmodule

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
/* shared types of the DMA engine
   32-bit words only, byte k of a word goes to lane k */
`default_nettype none

package dma_pkg;

	// one data word, seen whole by the memories or as bytes by the lanes
	typedef union packed
	{
		logic [31:0] word;	// memory side view
		logic [3:0][7:0] lane;	// lane k owns byte k
	} dma_word_u;

	// one data beat between pipeline stages
	typedef struct packed
	{
		logic valid;	// data present this cycle
		dma_word_u data;
	} dma_beat_s;

	// transfer command, held as a level by the register slave
	typedef struct packed
	{
		logic [31:0] read_addr;	// first source byte address
		logic [31:0] write_addr;	// first destination byte address
		logic [31:0] length;	// bytes, multiple of 4
		logic fixed_read;	// hold the read address
		logic fixed_write;	// hold the write address
	} dma_cmd_s;

endpackage

`default_nettype wire

// ==== hdl/dma_read_master.sv ====
/* read master, one read per cycle, source memory has a fixed one cycle latency
   and no back-pressure; a go during a transfer restarts it */
`default_nettype none
`include "dma_settings.svh"

module dma_read_master
(
	input wire clk,
	input wire reset,
	input dma_pkg::dma_cmd_s cmd,
	input wire go,
	output logic [31:0] src_address,
	output logic src_read,
	input wire [31:0] src_readdata,
	output dma_pkg::dma_beat_s rd_beat
);

	logic [31:0] words_left;	// reads still to issue
	logic rd_valid;	// src_read delayed by the memory latency

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			src_address <= '0;
			words_left <= '0;
		end
		else if (go)
		begin
			src_address <= cmd.read_addr;
			words_left <= cmd.length / `DMA_WORD_BYTES;
		end
		else if (src_read)
		begin
			words_left <= words_left - 32'd1;
			if (!cmd.fixed_read)
				src_address <= src_address + `DMA_WORD_BYTES;
		end
	end

	assign src_read = (words_left != '0);	// first read the cycle after go

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= src_read;
	end

	assign rd_beat = {rd_valid, src_readdata};	// data straight from memory

endmodule

`default_nettype wire

// ==== hdl/dma_top.sv ====
/* DMA engine top, register slave, read master, four byte lanes, write master
   both memory ports take one access per cycle and never stall */
`default_nettype none

module dma_top
(
	input wire clk,
	input wire reset,
	input wire [2:0] slave_address,
	input wire slave_read,
	output wire [31:0] slave_readdata,
	input wire slave_write,
	input wire [31:0] slave_writedata,
	input wire [3:0] slave_byteenable,
	output wire irq,
	output wire [31:0] src_address,
	output wire src_read,
	input wire [31:0] src_readdata,
	output wire [31:0] dst_address,
	output wire dst_write,
	output wire [31:0] dst_writedata
);

	import dma_pkg::*;

	wire dma_cmd_s cmd;	// level from the slave
	wire go;	// one cycle start pulse
	wire clear;	// one cycle sum clear pulse
	wire done;
	wire dma_beat_s rd_beat;	// read master to lanes
	wire dma_beat_s wr_beat;	// lanes to write master
	wire [3:0] lane_valid;	// all lanes move together
	wire [3:0][7:0] lane_sum;

	dma_csr u_csr
	(
		.clk(clk),
		.reset(reset),
		.slave_address(slave_address),
		.slave_read(slave_read),
		.slave_readdata(slave_readdata),
		.slave_write(slave_write),
		.slave_writedata(slave_writedata),
		.slave_byteenable(slave_byteenable),
		.done(done),
		.lane_sum(lane_sum),
		.cmd(cmd),
		.go(go),
		.clear(clear),
		.irq(irq)
	);

	dma_read_master u_rd
	(
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.go(go),
		.src_address(src_address),
		.src_read(src_read),
		.src_readdata(src_readdata),
		.rd_beat(rd_beat)
	);

	for (genvar k = 0; k < 4; k++)
	begin : g_lane
		lane_checksum u_lane
		(
			.clk(clk),
			.reset(reset),
			.clear(clear),
			.in_valid(rd_beat.valid),
			.in_byte(rd_beat.data.lane[k]),
			.out_valid(lane_valid[k]),
			.out_byte(wr_beat.data.lane[k]),
			.sum(lane_sum[k])
		);
	end

	assign wr_beat.valid = lane_valid[0];	// lane 0 speaks for the word

	dma_write_master u_wr
	(
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.go(go),
		.wr_beat(wr_beat),
		.dst_address(dst_address),
		.dst_write(dst_write),
		.dst_writedata(dst_writedata),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== hdl/dma_write_master.sv ====
/* write master, every valid beat becomes one destination write in the same cycle
   destination accepts every write; done is high when no transfer is running */
`default_nettype none
`include "dma_settings.svh"

module dma_write_master
(
	input wire clk,
	input wire reset,
	input dma_pkg::dma_cmd_s cmd,
	input wire go,
	input dma_pkg::dma_beat_s wr_beat,
	output logic [31:0] dst_address,
	output logic dst_write,
	output logic [31:0] dst_writedata,
	output logic done
);

	logic [31:0] words_left;	// writes still expected

	assign dst_write = wr_beat.valid;
	assign dst_writedata = wr_beat.data.word;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			dst_address <= '0;
			words_left <= '0;
		end
		else if (go)
		begin
			dst_address <= cmd.write_addr;
			words_left <= cmd.length / `DMA_WORD_BYTES;
		end
		else if (dst_write)
		begin
			words_left <= words_left - 32'd1;
			if (!cmd.fixed_write)
				dst_address <= dst_address + `DMA_WORD_BYTES;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			done <= 1'b1;	// idle out of reset
		else if (go)
			done <= 1'b0;
		else if (dst_write && (words_left == 32'd1))
			done <= 1'b1;	// high the cycle after the last write
		else if (words_left == '0)
			done <= 1'b1;	// zero length, up one cycle after go
	end

endmodule

`default_nettype wire

// ==== hdl/lane_checksum.sv ====
/* one byte lane, one cycle of latency, running modulo-256 sum of valid bytes
   clear wins over a valid byte in the same cycle */
`default_nettype none

module lane_checksum
(
	input wire clk,
	input wire reset,
	input wire clear,
	input wire in_valid,
	input wire [7:0] in_byte,
	output logic out_valid,
	output logic [7:0] out_byte,
	output logic [7:0] sum
);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		out_byte <= in_byte;	// payload, qualified by out_valid
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sum <= '0;
		else if (clear)
			sum <= '0;
		else if (in_valid)
			sum <= sum + in_byte;	// wraps at 256
	end

endmodule

`default_nettype wire

// ==== include/dma_settings.svh ====
/* register map, control bits and word size of the DMA engine
   word width is fixed at 32 bits, lengths must be a multiple of 4 bytes */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

`define DMA_ADDR_STATUS   3'd0	// bit 0 done, bit 1 busy, write clears
`define DMA_ADDR_READ     3'd1	// source start address
`define DMA_ADDR_WRITE    3'd2	// destination start address
`define DMA_ADDR_LENGTH   3'd3	// transfer length in bytes
`define DMA_ADDR_CHECKSUM 3'd4	// per lane sums, read only
`define DMA_ADDR_CONTROL  3'd6	// control bits below

`define DMA_CTRL_CLEAR  0	// zero the lane sums
`define DMA_CTRL_GO     3	// start a transfer
`define DMA_CTRL_IRQ_EN 4	// route status done to irq
`define DMA_CTRL_RCON   8	// fixed read address
`define DMA_CTRL_WCON   9	// fixed write address

`define DMA_WORD_BYTES 4	// address step and length divisor

`endif

// ==== run_sim.sh ====
#!/bin/sh
# builds the DMA testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dma_tb -f flist.f -o dma_sim
./obj_dir/dma_sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation ok"

// ==== testbench/dma_chk.sv ====
/* port assertions of the DMA engine, bound into dma_top
   irq enable is read from the register slave's control register */
`default_nettype none
`include "dma_settings.svh"

module dma_chk
(
	input wire clk,
	input wire reset,
	input wire src_read,
	input wire dst_write,
	input wire done,
	input wire irq,
	input wire irq_en
);

	// no memory traffic while reset is high
	a_read_in_reset: assert property (@(posedge clk) reset |-> !src_read)
		else $error("source read while reset is high");

	a_write_in_reset: assert property (@(posedge clk) reset |-> !dst_write)
		else $error("destination write while reset is high");

	a_write_when_busy: assert property (@(posedge clk) disable iff (reset) dst_write |-> !done)
		else $error("destination write while done is high");	// writes belong to a transfer

	// irq only from a finished transfer with irq enable set
	a_irq_enabled: assert property (@(posedge clk) disable iff (reset) irq |-> irq_en && done)
		else $error("irq high with irq enable clear or a transfer running");

endmodule

bind dma_top dma_chk u_chk
(
	.clk(clk),
	.reset(reset),
	.src_read(src_read),
	.dst_write(dst_write),
	.done(done),
	.irq(irq),
	.irq_en(u_csr.control_reg[`DMA_CTRL_IRQ_EN])
);

`default_nettype wire

// ==== testbench/dma_tb.sv ====
/* testbench of the DMA engine, source and destination memories of 256 words each
   transfers must stay inside the first 1 KB of both address spaces */
`default_nettype none
`include "dma_settings.svh"

module dma_tb;

	localparam int XFER_WORDS = 32 + 8 + 12 + 12 + 0;	// all transfers below
	localparam int CYCLE_LIMIT = 4 * XFER_WORDS + 200;

	logic clk;
	logic reset;
	logic [2:0] slave_address;
	logic slave_read;
	logic slave_write;
	logic [31:0] slave_writedata;
	logic [3:0] slave_byteenable;
	logic [31:0] src_readdata;
	wire [31:0] slave_readdata;
	wire irq;
	wire [31:0] src_address;
	wire src_read;
	wire [31:0] dst_address;
	wire dst_write;
	wire [31:0] dst_writedata;

	logic [31:0] src_mem [0:255];
	logic [31:0] dst_mem [0:255];
	logic [31:0] exp_dst [0:255];	// destination as it should look
	logic [3:0][7:0] exp_sum;	// lane k sum in byte k
	logic [31:0] exp_ra_q [$];	// expected source addresses
	logic [31:0] exp_wa_q [$];	// expected destination addresses
	logic [31:0] exp_wd_q [$];	// expected destination data
	logic rd_pend = 1'b0;	// a read was issued last cycle
	logic [7:0] rd_pend_idx = '0;
	int errors = 0;
	int cycles = 0;
	int reads_seen;
	int writes_seen;
	int first_read;
	int first_write;
	int ctrl_cycle;	// cycle of the control write that starts a transfer

	dma_top uut
	(
		.clk(clk),
		.reset(reset),
		.slave_address(slave_address),
		.slave_read(slave_read),
		.slave_readdata(slave_readdata),
		.slave_write(slave_write),
		.slave_writedata(slave_writedata),
		.slave_byteenable(slave_byteenable),
		.irq(irq),
		.src_address(src_address),
		.src_read(src_read),
		.src_readdata(src_readdata),
		.dst_address(dst_address),
		.dst_write(dst_write),
		.dst_writedata(dst_writedata)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			errors++;
			$display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	// called on a falling edge, returns on the next one
	task automatic reg_write(input logic [2:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		slave_address = addr;
		slave_writedata = data;
		slave_byteenable = be;
		slave_write = 1'b1;
		@(negedge clk);
		slave_write = 1'b0;
	endtask

	task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
		slave_address = addr;
		slave_read = 1'b1;
		@(negedge clk);
		slave_read = 1'b0;
		data = slave_readdata;	// one cycle read latency
	endtask

	task automatic reg_expect(input logic [2:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] v;
		reg_read(addr, v);
		compare_value(name, expected, v);
	endtask

	// expected accesses, destination contents and lane sums of one transfer
	function automatic void ref_transfer(input logic [31:0] ra, input logic [31:0] wa,
		input logic [31:0] len, input logic fr, input logic fw);
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] word;
		int n;
		int k;
		r = ra;
		w = wa;
		for (n = 0; n < int'(len / `DMA_WORD_BYTES); n++)
		begin
			word = src_mem[r[9:2]];
			exp_ra_q.push_back(r);
			exp_wa_q.push_back(w);
			exp_wd_q.push_back(word);
			exp_dst[w[9:2]] = word;	// fixed write leaves the last word
			for (k = 0; k < 4; k++)
				exp_sum[k] = exp_sum[k] + word[8*k +: 8];	// modulo 256
			if (!fr)
				r = r + `DMA_WORD_BYTES;
			if (!fw)
				w = w + `DMA_WORD_BYTES;
		end
	endfunction

	task automatic run_transfer(input logic [31:0] ra, input logic [31:0] wa,
		input logic [31:0] len, input logic fr, input logic fw, input logic ie);
		logic [31:0] ctrl;
		logic [31:0] v;
		int words;
		int i;
		words = int'(len / `DMA_WORD_BYTES);
		reg_write(`DMA_ADDR_READ, ra, 4'hf);
		reg_write(`DMA_ADDR_WRITE, wa, 4'hf);
		reg_write(`DMA_ADDR_LENGTH, len, 4'hf);
		ref_transfer(ra, wa, len, fr, fw);
		reads_seen = 0;
		writes_seen = 0;
		first_read = -1;
		first_write = -1;
		ctrl = '0;
		ctrl[`DMA_CTRL_GO] = 1'b1;
		ctrl[`DMA_CTRL_IRQ_EN] = ie;
		ctrl[`DMA_CTRL_RCON] = fr;
		ctrl[`DMA_CTRL_WCON] = fw;
		ctrl_cycle = cycles;
		reg_write(`DMA_ADDR_CONTROL, ctrl, 4'hf);
		do
			reg_read(`DMA_ADDR_STATUS, v);	// status is cleared before each run
		while (v != 32'h1);
		compare_value("reads issued", words, reads_seen);
		compare_value("writes issued", words, writes_seen);
		compare_value("writes outstanding", 0, exp_wd_q.size());
		if (words > 0)
		begin
			compare_value("first read delay", 2, first_read - ctrl_cycle);	// go, then read
			compare_value("first write delay", 2, first_write - first_read);
		end
		compare_value("irq", {31'd0, ie}, {31'd0, irq});
		reg_expect(`DMA_ADDR_CHECKSUM, exp_sum, "checksum");
		reg_write(`DMA_ADDR_STATUS, 32'h0, 4'hf);
		compare_value("irq after status clear", 0, {31'd0, irq});
		reg_expect(`DMA_ADDR_STATUS, 32'h0, "status after clear");
		for (i = 0; i < 256; i++)
			compare_value($sformatf("dst_mem[%0d]", i), exp_dst[i], dst_mem[i]);
	endtask

	// source memory, data shows up the cycle after src_read
	always @(negedge clk)
	begin
		if (rd_pend)
			src_readdata <= src_mem[rd_pend_idx];
		rd_pend <= src_read;
		rd_pend_idx <= src_address[9:2];
	end

	// compares every memory access against the reference queues
	always @(negedge clk)
	begin
		if (!reset && src_read)
		begin
			reads_seen++;
			if (first_read < 0)
				first_read = cycles;
			if (exp_ra_q.size() == 0)
			begin
				errors++;
				$display("Source read at %0t that no transfer asked for", $time);
			end
			else
				compare_value("src_address", exp_ra_q.pop_front(), src_address);
		end
		if (!reset && dst_write)
		begin
			writes_seen++;
			if (first_write < 0)
				first_write = cycles;
			dst_mem[dst_address[9:2]] = dst_writedata;
			if (exp_wd_q.size() == 0)
			begin
				errors++;
				$display("Destination write at %0t that no transfer asked for", $time);
			end
			else
			begin
				compare_value("dst_address", exp_wa_q.pop_front(), dst_address);
				compare_value("dst_writedata", exp_wd_q.pop_front(), dst_writedata);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout, the run went past %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	initial
	begin
		int i;
		reset = 1'b1;
		slave_address = '0;
		slave_read = 1'b0;
		slave_write = 1'b0;
		slave_writedata = '0;
		slave_byteenable = '0;
		src_readdata = '0;
		exp_sum = '0;
		reads_seen = 0;
		writes_seen = 0;
		first_read = -1;
		first_write = -1;
		ctrl_cycle = 0;
		void'($urandom(32'h170e_d9f8));
		for (i = 0; i < 256; i++)
		begin
			src_mem[i] = $urandom();
			dst_mem[i] = 32'hd500_0000 + i;	// untouched words stay recognizable
			exp_dst[i] = 32'hd500_0000 + i;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// register access, byte enables and unmapped addresses
		reg_expect(`DMA_ADDR_STATUS, 32'h0, "status after reset");
		reg_write(`DMA_ADDR_READ, 32'h1234_5678, 4'hf);
		reg_write(`DMA_ADDR_READ, 32'haabb_ccdd, 4'b0101);
		reg_expect(`DMA_ADDR_READ, 32'h12bb_56dd, "read address");
		reg_write(`DMA_ADDR_WRITE, 32'h0bad_f00d, 4'hf);
		reg_expect(`DMA_ADDR_WRITE, 32'h0bad_f00d, "write address");
		reg_write(`DMA_ADDR_LENGTH, 32'h0000_0100, 4'hf);
		reg_write(`DMA_ADDR_LENGTH, 32'h1234_ff56, 4'b0010);
		reg_expect(`DMA_ADDR_LENGTH, 32'h0000_ff00, "length");
		reg_write(`DMA_ADDR_CONTROL, 32'h0000_0300, 4'hf);
		reg_write(`DMA_ADDR_CONTROL, 32'h0000_0308, 4'b1110);	// go bit without byte 0
		reg_expect(`DMA_ADDR_CONTROL, 32'h0000_0300, "control");
		reg_expect(3'd5, 32'h0, "unmapped address 5");
		reg_expect(3'd7, 32'h0, "unmapped address 7");
		reg_expect(`DMA_ADDR_CHECKSUM, 32'h0, "checksum after reset");
		compare_value("reads without go", 0, reads_seen);

		run_transfer(32'h000, 32'h200, 32'd128, 1'b0, 1'b0, 1'b1);	// incrementing
		run_transfer(32'h100, 32'h300, 32'd32, 1'b1, 1'b1, 1'b0);	// fixed addresses

		reg_write(`DMA_ADDR_CONTROL, 32'h1 << `DMA_CTRL_CLEAR, 4'h1);
		exp_sum = '0;
		@(negedge clk);	// sums drop the cycle after the clear pulse
		reg_expect(`DMA_ADDR_CHECKSUM, 32'h0, "checksum after clear");
		run_transfer(32'h040, 32'h240, 32'd48, 1'b0, 1'b0, 1'b1);
		run_transfer(32'h080, 32'h280, 32'd48, 1'b0, 1'b0, 1'b0);	// sums accumulate
		run_transfer(32'h000, 32'h3f0, 32'd0, 1'b0, 1'b0, 1'b1);	// zero length

		$display("Run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
